// File: meta_fpu_defines.svh
// SIMD floating-point side unit, shared width definitions
// Sizes of the operand word, the byte enables, the destination register
// index and the issue tag

`ifndef META_FPU_DEFINES_SVH
`define META_FPU_DEFINES_SVH

// Operand and result word width
`define FPU_WID 64

// One write enable and one copy-target bit per byte of the word
`define FPU_BYTES 8

// Destination register index width, index zero is never written
`define FPU_REG_W 5

// Issue tag width
`define FPU_TAG_W 4

`endif

// File: meta_fpu_pkg.sv
// SIMD floating-point side unit, shared types
// Vector types for operands, masks, register indices and tags, plus the
// operation, precision and exception cause encodings

`default_nettype none

package meta_fpu_pkg;

`include "meta_fpu_defines.svh"

	typedef logic [`FPU_WID-1:0]   fpu_data_t;
	typedef logic [`FPU_BYTES-1:0] byte_mask_t;
	typedef logic [`FPU_REG_W-1:0] reg_idx_t;
	typedef logic [`FPU_TAG_W-1:0] fpu_tag_t;
	typedef logic [31:0]           instr_t;

	// Operation codes from instruction bits 2:0, codes 6 and 7 are reserved
	typedef enum logic [2:0] {
		OP_SGNJ  = 3'd0,
		OP_SGNJN = 3'd1,
		OP_SGNJX = 3'd2,
		OP_MIN   = 3'd3,
		OP_MAX   = 3'd4,
		OP_CMPLT = 3'd5
	} fpu_op_e;

	// Lane precision from instruction bits 5:4
	typedef enum logic [1:0] {
		PREC_H = 2'd0,
		PREC_S = 2'd1,
		PREC_D = 2'd2,
		PREC_X = 2'd3
	} fpu_prec_e;

	typedef enum logic [1:0] {
		CAUSE_NONE    = 2'd0,
		CAUSE_INVALID = 2'd1,
		CAUSE_ILLEGAL = 2'd2
	} cause_e;

endpackage

`default_nettype wire

// File: fpu_decode.sv
// Instruction decoder for the SIMD floating-point side unit
// Pulls the operation and precision fields out of the instruction word and
// flags reserved encodings, purely combinational

`timescale 1ns/1ns
`default_nettype none

module fpu_decode import meta_fpu_pkg::*; (
	input  instr_t    instr_i,
	output fpu_op_e   op_o,
	output fpu_prec_e prec_o,
	output logic      illegal_o
);

	// ========================================================================
	// Field extraction
	// ========================================================================

	logic [2:0] op_field;
	logic [1:0] prec_field;
	logic       op_bad;
	logic       prec_bad;

	// Operation code lives in the low three bits
	assign op_field   = instr_i[2:0];
	// Bit 3 is unused by this unit
	assign prec_field = instr_i[5:4];

	// Reserved codes still go out on op_o, the lanes give zero for them
	assign op_o   = fpu_op_e'(op_field);
	assign prec_o = fpu_prec_e'(prec_field);

	// ========================================================================
	// Legality
	// ========================================================================

	// Codes above CMPLT have no lane operation behind them
	always_comb begin
		case (op_field)
		OP_SGNJ, OP_SGNJN, OP_SGNJX: op_bad = 1'b0;
		OP_MIN, OP_MAX, OP_CMPLT:    op_bad = 1'b0;
		default:                     op_bad = 1'b1;
		endcase
	end

	// Precision 3 would be quad, which this unit does not carry
	assign prec_bad = (prec_field == PREC_X);

	// Either fault zeroes the result and the write enables downstream
	assign illegal_o = op_bad | prec_bad;

endmodule

`default_nettype wire

// File: fpu_lane.sv
// One floating-point lane of the SIMD side unit
// Performs sign injection, minimum, maximum and less-than compare on a
// half, single or double operand pair and registers the result together
// with its invalid-operation flag after one cycle

`timescale 1ns/1ns
`default_nettype none

module fpu_lane import meta_fpu_pkg::*; #(
	parameter int LANE_W = 32
) (
	input  logic              clk,
	input  logic              rst_n_i,
	input  fpu_op_e           op_i,
	input  logic [LANE_W-1:0] a_i,
	input  logic [LANE_W-1:0] b_i,
	output logic [LANE_W-1:0] res_o,
	output logic              invalid_o
);

	// Exponent width follows the IEEE format of the lane width
	localparam int EXP_W  = (LANE_W == 16) ? 5 : (LANE_W == 32) ? 8 : 11;
	localparam int FRAC_W = LANE_W - EXP_W - 1;

	// Canonical quiet NaN has a clear sign and only the top fraction bit set
	localparam logic [LANE_W-1:0] QNAN = {1'b0, {EXP_W{1'b1}}, 1'b1, {(FRAC_W-1){1'b0}}};

	logic              sgn_a, sgn_b;
	logic [LANE_W-2:0] mag_a, mag_b;
	logic              nan_a, nan_b;
	logic              snan_a, snan_b;
	logic              zero_a, zero_b;
	logic              lt;
	logic [LANE_W-1:0] res_d;
	logic              inv_d;

	// ========================================================================
	// Operand classification
	// ========================================================================

	assign sgn_a = a_i[LANE_W-1];
	assign sgn_b = b_i[LANE_W-1];
	assign mag_a = a_i[LANE_W-2:0];
	assign mag_b = b_i[LANE_W-2:0];

	// A NaN has an all-ones exponent and a non-zero fraction
	assign nan_a  = (&a_i[LANE_W-2 -: EXP_W]) & (|a_i[FRAC_W-1:0]);
	assign nan_b  = (&b_i[LANE_W-2 -: EXP_W]) & (|b_i[FRAC_W-1:0]);
	// Signaling when the quiet bit at the top of the fraction is clear
	assign snan_a = nan_a & ~a_i[FRAC_W-1];
	assign snan_b = nan_b & ~b_i[FRAC_W-1];
	// Zero of either sign
	assign zero_a = ~|mag_a;
	assign zero_b = ~|mag_b;

	// Sign-magnitude ordering, so -0 sorts below +0 here
	always_comb begin
		if (sgn_a != sgn_b)
			lt = sgn_a;
		else if (sgn_a)
			lt = (mag_a > mag_b);
		else
			lt = (mag_a < mag_b);
	end

	// ========================================================================
	// Operation select
	// ========================================================================

	always_comb begin
		res_d = '0;
		inv_d = 1'b0;
		case (op_i)
		// Sign injection keeps the magnitude of a and never raises invalid
		OP_SGNJ:  res_d = {sgn_b, mag_a};
		OP_SGNJN: res_d = {~sgn_b, mag_a};
		OP_SGNJX: res_d = {sgn_a ^ sgn_b, mag_a};
		OP_MIN, OP_MAX: begin
			if (nan_a & nan_b)
				res_d = QNAN;
			else if (nan_a)
				res_d = b_i;
			else if (nan_b)
				res_d = a_i;
			else if (op_i == OP_MIN)
				res_d = lt ? a_i : b_i;
			else
				res_d = lt ? b_i : a_i;
			// Only a signaling NaN is an invalid operation for min and max
			inv_d = snan_a | snan_b;
		end
		OP_CMPLT: begin
			// Compare treats the two zeros as equal, and any NaN as unordered
			res_d = {{(LANE_W-1){1'b0}}, lt & ~(zero_a & zero_b) & ~(nan_a | nan_b)};
			inv_d = nan_a | nan_b;
		end
		default: ;
		endcase
	end

	// Lane result register
	always_ff @(posedge clk) begin
		res_o <= res_d;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i)
			invalid_o <= 1'b0;
		else
			invalid_o <= inv_d;
	end

endmodule

`default_nettype wire

// File: meta_fpu.sv
// Multi-precision SIMD floating-point datapath
// Runs half, single and double lanes side by side on every issue, picks
// the set named by the precision, merges copy-target bytes and squashes the
// write enables of flushed operations, with a fixed two-cycle latency

`timescale 1ns/1ns
`default_nettype none

`include "meta_fpu_defines.svh"

module meta_fpu import meta_fpu_pkg::*; (
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       issue_i,
	input  logic       flush_i,
	input  fpu_op_e    op_i,
	input  fpu_prec_e  prec_i,
	input  logic       illegal_i,
	input  fpu_data_t  a_i,
	input  fpu_data_t  b_i,
	input  fpu_data_t  t_i,
	input  byte_mask_t cptgt_i,
	input  logic       z_i,
	input  reg_idx_t   rd_i,
	input  fpu_tag_t   tag_i,
	output fpu_data_t  o_o,
	output reg_idx_t   rd_o,
	output fpu_tag_t   tag_o,
	output byte_mask_t we_o,
	output logic       done_o,
	output cause_e     exc_o
);

	localparam int N_H = `FPU_WID / 16;
	localparam int N_S = `FPU_WID / 32;
	localparam int N_D = `FPU_WID / 64;

	fpu_data_t      o16, o32, o64, sel, mrg;
	logic [N_H-1:0] inv16;
	logic [N_S-1:0] inv32;
	logic [N_D-1:0] inv64;
	byte_mask_t     inv_b;
	// Stage 1 side information travelling with the lanes
	logic v1, z1, ill1;
	fpu_data_t  t1;
	byte_mask_t cptgt1;
	fpu_prec_e  prec1;
	reg_idx_t   rd1;
	fpu_tag_t   tag1;
	// Flush conveyor with bit 0 at stage 1 and bit 1 at stage 2
	logic [1:0] stomp_con;
	byte_mask_t we_q;

	// ========================================================================
	// Lanes of every precision computing on every issue
	// ========================================================================

	for (genvar g = 0; g < N_H; g++) begin : g_h
		fpu_lane #(.LANE_W(16)) u_lane (.clk(clk), .rst_n_i(rst_n_i), .op_i(op_i),
			.a_i(a_i[g*16 +: 16]), .b_i(b_i[g*16 +: 16]),
			.res_o(o16[g*16 +: 16]), .invalid_o(inv16[g]));
	end
	for (genvar g = 0; g < N_S; g++) begin : g_s
		fpu_lane #(.LANE_W(32)) u_lane (.clk(clk), .rst_n_i(rst_n_i), .op_i(op_i),
			.a_i(a_i[g*32 +: 32]), .b_i(b_i[g*32 +: 32]),
			.res_o(o32[g*32 +: 32]), .invalid_o(inv32[g]));
	end
	for (genvar g = 0; g < N_D; g++) begin : g_d
		fpu_lane #(.LANE_W(64)) u_lane (.clk(clk), .rst_n_i(rst_n_i), .op_i(op_i),
			.a_i(a_i[g*64 +: 64]), .b_i(b_i[g*64 +: 64]),
			.res_o(o64[g*64 +: 64]), .invalid_o(inv64[g]));
	end

	// Stage 1 copies of the merge inputs and the side information
	always_ff @(posedge clk) begin
		t1     <= t_i;
		cptgt1 <= cptgt_i;
		z1     <= z_i;
		prec1  <= prec_i;
		ill1   <= illegal_i;
		rd1    <= rd_i;
		tag1   <= tag_i;
	end

	// ========================================================================
	// Precision select and copy-target merge
	// ========================================================================

	always_comb begin
		case (prec1)
		PREC_H:  sel = o16;
		PREC_S:  sel = o32;
		PREC_D:  sel = o64;
		default: sel = '0;
		endcase
	end

	for (genvar m = 0; m < `FPU_BYTES; m++) begin : g_byte
		logic lane_inv;

		// Invalid flag of the lane that owns this byte
		always_comb begin
			case (prec1)
			PREC_H:  lane_inv = inv16[m/2];
			PREC_S:  lane_inv = inv32[m/4];
			PREC_D:  lane_inv = inv64[m/8];
			default: lane_inv = 1'b0;
			endcase
		end

		// A copied byte hides whatever its lane flagged
		assign inv_b[m] = lane_inv & ~cptgt1[m];
		assign mrg[m*8 +: 8] = cptgt1[m] ? (z1 ? 8'h00 : t1[m*8 +: 8]) : sel[m*8 +: 8];
	end

	// ========================================================================
	// Flush conveyor and stage 2 output registers
	// ========================================================================

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			v1        <= 1'b0;
			stomp_con <= 2'b00;
			done_o    <= 1'b0;
			we_q      <= '0;
			exc_o     <= CAUSE_NONE;
		end else begin
			v1     <= issue_i;
			done_o <= v1;
			// Register zero is a discard target and counts as a flush
			stomp_con[0] <= issue_i & (flush_i | ~|rd_i);
			if (v1) begin
				stomp_con[1] <= flush_i | stomp_con[0];
				we_q         <= ill1 ? '0 : '1;
				if (ill1)
					exc_o <= CAUSE_ILLEGAL;
				else if (|inv_b)
					exc_o <= CAUSE_INVALID;
				else
					exc_o <= CAUSE_NONE;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (v1) begin
			o_o   <= ill1 ? '0 : mrg;
			rd_o  <= rd1;
			tag_o <= tag1;
		end
	end

	// Squashed operations still complete, just without writing anything
	assign we_o = stomp_con[1] ? '0 : we_q;

endmodule

`default_nettype wire

// File: fpu_status.sv
// Floating-point status collector
// Keeps a sticky invalid-operation flag and a saturating count of
// completions that reported an invalid operation

`timescale 1ns/1ns
`default_nettype none

module fpu_status import meta_fpu_pkg::*; (
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       done_i,
	input  cause_e     exc_i,
	input  logic       clr_i,
	output logic       invalid_o,
	output logic [7:0] invalid_cnt_o
);

	logic hit;

	// Only completing operations with an invalid cause count
	assign hit = done_i & (exc_i == CAUSE_INVALID);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			invalid_o     <= 1'b0;
			invalid_cnt_o <= 8'd0;
		end else if (clr_i) begin
			// Clear wins over a completion in the same cycle
			invalid_o     <= 1'b0;
			invalid_cnt_o <= 8'd0;
		end else if (hit) begin
			invalid_o <= 1'b1;
			// Counter sticks at its top value
			if (invalid_cnt_o != 8'hFF)
				invalid_cnt_o <= invalid_cnt_o + 8'd1;
		end
	end

endmodule

`default_nettype wire

// File: fpu_top.sv
// Top level of the SIMD floating-point side unit
// Decodes the issued instruction, runs it through the multi-precision
// datapath and collects invalid-operation status from its completions

`timescale 1ns/1ns
`default_nettype none

module fpu_top import meta_fpu_pkg::*; (
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       issue_i,
	input  instr_t     instr_i,
	input  fpu_data_t  a_i,
	input  fpu_data_t  b_i,
	input  fpu_data_t  t_i,
	input  byte_mask_t cptgt_i,
	input  logic       z_i,
	input  reg_idx_t   rd_i,
	input  fpu_tag_t   tag_i,
	input  logic       flush_i,
	input  logic       clr_status_i,
	output fpu_data_t  o_o,
	output reg_idx_t   rd_o,
	output fpu_tag_t   tag_o,
	output byte_mask_t we_o,
	output logic       done_o,
	output cause_e     exc_o,
	output logic       invalid_o,
	output logic [7:0] invalid_cnt_o
);

	fpu_op_e   op;
	fpu_prec_e prec;
	logic      illegal;

	// Decode sits in the issue cycle ahead of the lanes
	fpu_decode u_decode (.instr_i(instr_i), .op_o(op), .prec_o(prec), .illegal_o(illegal));

	meta_fpu u_meta_fpu (
		.clk(clk), .rst_n_i(rst_n_i), .issue_i(issue_i), .flush_i(flush_i),
		.op_i(op), .prec_i(prec), .illegal_i(illegal),
		.a_i(a_i), .b_i(b_i), .t_i(t_i), .cptgt_i(cptgt_i), .z_i(z_i),
		.rd_i(rd_i), .tag_i(tag_i),
		.o_o(o_o), .rd_o(rd_o), .tag_o(tag_o), .we_o(we_o),
		.done_o(done_o), .exc_o(exc_o)
	);

	// Status follows the completion stream one cycle later
	fpu_status u_status (
		.clk(clk), .rst_n_i(rst_n_i), .done_i(done_o), .exc_i(exc_o),
		.clr_i(clr_status_i), .invalid_o(invalid_o), .invalid_cnt_o(invalid_cnt_o)
	);

endmodule

`default_nettype wire

// File: tb_fpu_top.sv
// Testbench for the SIMD floating-point side unit
// Drives random and directed operations at every precision, models the
// expected results, write enables and status, and checks them on each
// completion

`timescale 1ns/1ns
`default_nettype none

module tb_fpu_top import meta_fpu_pkg::*; ();

	localparam int N_RAND    = 8;
	localparam int N_MERGE   = 24;
	localparam int N_SAT     = 260;
	// Issues of the latency, random, corner, merge, copied lane, write enable
	// and counter saturation tests
	localparam int N_ISSUE   = 5 + 3 * 6 * N_RAND + 3 * 10 + N_MERGE + 2 + 8 + N_SAT;
	localparam int CYC_LIMIT = 2 * N_ISSUE + 100;

	typedef struct {
		fpu_data_t o;
		cause_e    exc;
		logic      ill;
		logic      stomp;
		reg_idx_t  rd;
		fpu_tag_t  tag;
		int        due;
	} exp_t;

	logic       clk;
	logic       rst_n_i;
	logic       issue_i;
	instr_t     instr_i;
	fpu_data_t  a_i, b_i, t_i;
	byte_mask_t cptgt_i;
	logic       z_i;
	reg_idx_t   rd_i;
	fpu_tag_t   tag_i;
	logic       flush_i;
	logic       clr_status_i;
	fpu_data_t  o_o;
	reg_idx_t   rd_o;
	fpu_tag_t   tag_o;
	byte_mask_t we_o;
	logic       done_o;
	cause_e     exc_o;
	logic       invalid_o;
	logic [7:0] invalid_cnt_o;

	logic [31:0] lfsr = 32'd86;
	exp_t        exp_q[$];
	int          cyc = 0;
	int          clk_cnt = 0;
	logic        st_inv = 1'b0;
	logic [7:0]  st_cnt = 8'd0;

	fpu_top u_dut (
		.clk(clk), .rst_n_i(rst_n_i), .issue_i(issue_i), .instr_i(instr_i),
		.a_i(a_i), .b_i(b_i), .t_i(t_i), .cptgt_i(cptgt_i), .z_i(z_i),
		.rd_i(rd_i), .tag_i(tag_i), .flush_i(flush_i), .clr_status_i(clr_status_i),
		.o_o(o_o), .rd_o(rd_o), .tag_o(tag_o), .we_o(we_o), .done_o(done_o),
		.exc_o(exc_o), .invalid_o(invalid_o), .invalid_cnt_o(invalid_cnt_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		clk_cnt <= clk_cnt + 1;
		if (clk_cnt > CYC_LIMIT) begin
			$display("Timeout, the run went past its cycle limit");
			$display("SOME TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	// ========================================================================
	// Stimulus source and reference model
	// ========================================================================

	// Galois LFSR with taps 32 22 2 1 that steps once per bit taken
	function automatic logic [63:0] rbits(int n);
		logic [63:0] v;
		logic        lsb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lsb  = lfsr[0];
			lfsr = lfsr >> 1;
			if (lsb)
				lfsr = lfsr ^ 32'h80200003;
			v = {v[62:0], lsb};
		end
		return v;
	endfunction

	function automatic int exp_width(int w);
		return (w == 16) ? 5 : (w == 32) ? 8 : 11;
	endfunction

	// Random word where about a quarter of the lanes get an all-ones exponent
	function automatic fpu_data_t rand_operand(logic [1:0] prec);
		fpu_data_t v;
		int        w, ew;
		w  = 16 << prec;
		ew = exp_width(w);
		v  = rbits(64);
		for (int l = 0; l < 64 / w; l++)
			if (rbits(2) == 0)
				v = v | (((64'h1 << ew) - 1) << (l * w + w - 1 - ew));
		return v;
	endfunction

	// Fills every lane with zero, one, a quiet NaN or a signaling NaN for kind 0 to 3
	function automatic fpu_data_t fpval(int w, int kind, logic s);
		logic [63:0] v, r;
		int          ew, fw;
		ew = exp_width(w);
		fw = w - ew - 1;
		case (kind)
		1:       v = 64'((1 << (ew - 1)) - 1) << fw;
		2:       v = (((64'h1 << ew) - 1) << fw) | (64'h1 << (fw - 1)) | 64'h1;
		3:       v = (((64'h1 << ew) - 1) << fw) | 64'h1;
		default: v = '0;
		endcase
		v = v | (64'(s) << (w - 1));
		r = '0;
		for (int l = 0; l < 64 / w; l++)
			r = r | (v << (l * w));
		return r;
	endfunction

	// Expected result and invalid flag of one lane with right-aligned operands
	function automatic logic [63:0] ref_lane(int w, logic [2:0] op, logic [63:0] a,
			logic [63:0] b, output logic inv);
		int          ew, fw;
		logic        sa, sb, na, nb, za, zb, less;
		logic [63:0] ma, mb, em, r;
		ew = exp_width(w);
		fw = w - ew - 1;
		em = (64'h1 << ew) - 1;
		sa = a[w-1];
		sb = b[w-1];
		ma = a & ((64'h1 << (w - 1)) - 1);
		mb = b & ((64'h1 << (w - 1)) - 1);
		na = (((a >> fw) & em) == em) && ((a & ((64'h1 << fw) - 1)) != 0);
		nb = (((b >> fw) & em) == em) && ((b & ((64'h1 << fw) - 1)) != 0);
		za = (ma == 0);
		zb = (mb == 0);
		// Negative zero counts below positive zero here
		if (sa != sb)
			less = sa;
		else
			less = sa ? (ma > mb) : (ma < mb);
		r   = '0;
		inv = 1'b0;
		case (op)
		3'd0: r = (64'(sb) << (w - 1)) | ma;
		3'd1: r = (64'(!sb) << (w - 1)) | ma;
		3'd2: r = (64'(sa ^ sb) << (w - 1)) | ma;
		3'd3, 3'd4: begin
			if (na && nb)
				r = (em << fw) | (64'h1 << (fw - 1));
			else if (na)
				r = b;
			else if (nb)
				r = a;
			else
				r = ((op == 3'd3) == less) ? a : b;
			inv = (na && !a[fw-1]) || (nb && !b[fw-1]);
		end
		3'd5: begin
			r   = 64'(!na && !nb && !(za && zb) && less);
			inv = na || nb;
		end
		default: r = '0;
		endcase
		return r;
	endfunction

	function automatic fpu_data_t ref_word(logic [2:0] op, logic [1:0] prec,
			fpu_data_t a, fpu_data_t b, fpu_data_t t, byte_mask_t mask, logic z,
			output cause_e exc);
		fpu_data_t   res;
		logic [63:0] wm;
		logic [63:0] lr;
		logic [3:0]  linv;
		logic        li;
		int          w;
		exc = CAUSE_NONE;
		if (op > 3'd5 || prec == 2'd3) begin
			exc = CAUSE_ILLEGAL;
			return '0;
		end
		w    = 16 << prec;
		wm   = (w == 64) ? '1 : ((64'h1 << w) - 1);
		res  = '0;
		linv = '0;
		for (int l = 0; l < 64 / w; l++) begin
			lr      = ref_lane(w, op, (a >> (l * w)) & wm, (b >> (l * w)) & wm, li);
			res     = res | (lr << (l * w));
			linv[l] = li;
		end
		for (int m = 0; m < 8; m++) begin
			if (mask[m])
				res[m*8 +: 8] = z ? 8'h00 : t[m*8 +: 8];
			else if (linv[m * 8 / w])
				exc = CAUSE_INVALID;
		end
		return res;
	endfunction

	// ========================================================================
	// Checking and driving
	// ========================================================================

	task automatic check_val(string name, logic [63:0] got, logic [63:0] expv);
		assert (got === expv) else begin
			$display("ERROR time=%0t %s got=%h expected=%h", $time, name, got, expv);
			$display("SOME TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// Checks what the DUT shows in this cycle and then drives the next inputs
	task automatic do_cycle(logic iss, logic [2:0] op, logic [1:0] prec, fpu_data_t a,
			fpu_data_t b, fpu_data_t t, byte_mask_t mask, logic z, reg_idx_t rd,
			logic flush, logic clr);
		exp_t   e;
		cause_e exc;
		logic   hit_inv;
		@(negedge clk);
		hit_inv = 1'b0;
		check_val("invalid_o", 64'(invalid_o), 64'(st_inv));
		check_val("invalid_cnt_o", 64'(invalid_cnt_o), 64'(st_cnt));
		if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
			e = exp_q.pop_front();
			check_val("done_o", 64'(done_o), 64'd1);
			check_val("o_o", o_o, e.o);
			check_val("we_o", 64'(we_o), (e.stomp || e.ill) ? 64'h0 : 64'hFF);
			check_val("exc_o", 64'(exc_o), 64'(e.exc));
			check_val("rd_o", 64'(rd_o), 64'(e.rd));
			check_val("tag_o", 64'(tag_o), 64'(e.tag));
			hit_inv = (e.exc == CAUSE_INVALID);
		end else begin
			check_val("done_o", 64'(done_o), 64'd0);
		end
		issue_i      = iss;
		instr_i      = {26'd0, prec, 1'b0, op};
		a_i          = a;
		b_i          = b;
		t_i          = t;
		cptgt_i      = mask;
		z_i          = z;
		rd_i         = rd;
		tag_i        = fpu_tag_t'(rbits(4));
		flush_i      = flush;
		clr_status_i = clr;
		// A flush squashes the operation in stage 1 as well as a new one
		if (flush)
			foreach (exp_q[i])
				exp_q[i].stomp = 1'b1;
		if (iss) begin
			e.o     = ref_word(op, prec, a, b, t, mask, z, exc);
			e.exc   = exc;
			e.ill   = (exc == CAUSE_ILLEGAL);
			e.stomp = flush || (rd == 0);
			e.rd    = rd;
			e.tag   = tag_i;
			e.due   = cyc + 2;
			exp_q.push_back(e);
		end
		if (clr) begin
			st_inv = 1'b0;
			st_cnt = 8'd0;
		end else if (hit_inv) begin
			st_inv = 1'b1;
			if (st_cnt != 8'hFF)
				st_cnt = st_cnt + 8'd1;
		end
		cyc++;
	endtask

	function automatic reg_idx_t rand_rd();
		reg_idx_t r;
		r = reg_idx_t'(rbits(5));
		return (r == 0) ? reg_idx_t'(1) : r;
	endfunction

	task automatic issue_op(logic [2:0] op, logic [1:0] prec, fpu_data_t a, fpu_data_t b);
		do_cycle(1'b1, op, prec, a, b, '0, '0, 1'b0, rand_rd(), 1'b0, 1'b0);
	endtask

	task automatic idle(logic flush, logic clr);
		do_cycle(1'b0, 3'd0, 2'd0, '0, '0, '0, '0, 1'b0, '0, flush, clr);
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial begin
		int w;
		rst_n_i = 1'b0;
		issue_i = 1'b0;
		instr_i = '0;
		a_i = '0;
		b_i = '0;
		t_i = '0;
		cptgt_i = '0;
		z_i = 1'b0;
		rd_i = '0;
		tag_i = '0;
		flush_i = 1'b0;
		clr_status_i = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		check_val("done_o", 64'(done_o), 64'd0);
		check_val("we_o", 64'(we_o), 64'd0);
		check_val("exc_o", 64'(exc_o), 64'd0);

		// Latency with gaps and then back to back
		issue_op(3'd0, 2'd1, rand_operand(2'd1), rand_operand(2'd1));
		idle(1'b0, 1'b0);
		idle(1'b0, 1'b0);
		issue_op(3'd3, 2'd0, rand_operand(2'd0), rand_operand(2'd0));
		idle(1'b0, 1'b0);
		for (int i = 0; i < 3; i++)
			issue_op(3'd4, 2'd2, rand_operand(2'd2), rand_operand(2'd2));

		// Every operation at every precision with random operands
		for (int p = 0; p < 3; p++)
			for (int o = 0; o < 6; o++)
				for (int i = 0; i < N_RAND; i++)
					issue_op(3'(o), 2'(p), rand_operand(2'(p)), rand_operand(2'(p)));

		// NaN and signed zero corner cases
		for (int p = 0; p < 3; p++) begin
			w = 16 << p;
			issue_op(3'd3, 2'(p), fpval(w, 2, 1'b0), fpval(w, 1, 1'b1));
			issue_op(3'd4, 2'(p), fpval(w, 1, 1'b0), fpval(w, 3, 1'b0));
			issue_op(3'd3, 2'(p), fpval(w, 2, 1'b1), fpval(w, 3, 1'b0));
			issue_op(3'd4, 2'(p), fpval(w, 2, 1'b0), fpval(w, 2, 1'b1));
			issue_op(3'd3, 2'(p), fpval(w, 0, 1'b1), fpval(w, 0, 1'b0));
			issue_op(3'd4, 2'(p), fpval(w, 0, 1'b1), fpval(w, 0, 1'b0));
			issue_op(3'd3, 2'(p), fpval(w, 0, 1'b0), fpval(w, 0, 1'b1));
			issue_op(3'd5, 2'(p), fpval(w, 2, 1'b0), fpval(w, 1, 1'b0));
			issue_op(3'd5, 2'(p), fpval(w, 0, 1'b1), fpval(w, 0, 1'b0));
			issue_op(3'd5, 2'(p), fpval(w, 1, 1'b1), fpval(w, 1, 1'b0));
		end

		// Copy-target merge with status clears mixed in
		for (int i = 0; i < N_MERGE; i++)
			do_cycle(1'b1, 3'(3 + (i % 3)), 2'(i % 3), rand_operand(2'(i % 3)),
				rand_operand(2'(i % 3)), rbits(64), byte_mask_t'(rbits(8)),
				rbits(1) == 1, rand_rd(), 1'b0, rbits(3) == 0);

		// An invalid lane copied in full reports nothing, a partly kept one does
		do_cycle(1'b1, 3'd5, 2'd2, fpval(64, 2, 1'b0), fpval(64, 1, 1'b0), rbits(64),
			8'hFF, 1'b0, rand_rd(), 1'b0, 1'b0);
		do_cycle(1'b1, 3'd3, 2'd1, fpval(32, 3, 1'b0), fpval(32, 1, 1'b0), rbits(64),
			8'h0F, 1'b1, rand_rd(), 1'b0, 1'b0);

		// Write enable squashing
		do_cycle(1'b1, 3'd0, 2'd1, rbits(64), rbits(64), '0, '0, 1'b0, rand_rd(), 1'b1, 1'b0);
		issue_op(3'd2, 2'd0, rbits(64), rbits(64));
		idle(1'b1, 1'b0);
		issue_op(3'd1, 2'd2, rbits(64), rbits(64));
		do_cycle(1'b1, 3'd5, 2'd1, rbits(64), rbits(64), '0, '0, 1'b0, rand_rd(), 1'b1, 1'b0);
		do_cycle(1'b1, 3'd0, 2'd0, rbits(64), rbits(64), '0, '0, 1'b0, '0, 1'b0, 1'b0);
		issue_op(3'd6, 2'd1, rbits(64), rbits(64));
		issue_op(3'd7, 2'd0, rbits(64), rbits(64));
		issue_op(3'd3, 2'd3, rbits(64), rbits(64));

		// Enough invalid completions to drive the counter into saturation
		for (int i = 0; i < N_SAT; i++)
			issue_op(3'd5, 2'd2, fpval(64, 2, 1'b0), fpval(64, 1, 1'b0));

		// Drain with a clear that meets the last invalid completion
		idle(1'b0, 1'b0);
		idle(1'b0, 1'b1);
		idle(1'b0, 1'b0);
		idle(1'b0, 1'b0);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
meta_fpu_pkg.sv
fpu_decode.sv
fpu_lane.sv
meta_fpu.sv
fpu_status.sv
fpu_top.sv
tb_fpu_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log
verilator --binary --timing --assert -f sim.f --top-module tb_fpu_top -o sim_tb \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || grep -q "ALL TESTS PASSED" sim.log || exit 1
exit 0
